// ==== video_std_pkg.sv ====
package video_std_pkg;

    typedef enum logic {
        STD_NTSC = 1'b0,
        STD_PAL  = 1'b1
    } video_std_t;

    localparam int CNT_W = 10;  // h and v counters, 623 lines max

    // pal raster: 504 counts per line, 624 lines per frame
    localparam logic [CNT_W-1:0] PAL_HS_STA   = 10'd16;   // hsync start
    localparam logic [CNT_W-1:0] PAL_HS_END   = 10'd64;   // first pixel after hsync
    localparam logic [CNT_W-1:0] PAL_HA_STA   = 10'd129;  // active window start
    localparam logic [CNT_W-1:0] PAL_VS_STA   = 10'd580;  // vsync start line
    localparam logic [CNT_W-1:0] PAL_VS_END   = 10'd583;  // first line after vsync
    localparam logic [CNT_W-1:0] PAL_VA_END   = 10'd569;  // first blank line
    localparam logic [CNT_W-1:0] PAL_LINE     = 10'd503;  // last h count
    localparam logic [CNT_W-1:0] PAL_SCREEN   = 10'd623;  // last v count
    localparam logic [CNT_W-1:0] PAL_V_OFFSET = 10'd63;   // v start = SCREEN - this
    localparam logic [CNT_W-1:0] PAL_H_OFFSET = 10'd29;   // h where buffer pixel 0 shows

    // ntsc raster: 520 counts per line, 526 lines per frame
    localparam logic [CNT_W-1:0] NTSC_HS_STA   = 10'd16;
    localparam logic [CNT_W-1:0] NTSC_HS_END   = 10'd64;
    localparam logic [CNT_W-1:0] NTSC_HA_STA   = 10'd129;
    localparam logic [CNT_W-1:0] NTSC_VS_STA   = 10'd512;
    localparam logic [CNT_W-1:0] NTSC_VS_END   = 10'd515;
    localparam logic [CNT_W-1:0] NTSC_VA_END   = 10'd502;
    localparam logic [CNT_W-1:0] NTSC_LINE     = 10'd519;
    localparam logic [CNT_W-1:0] NTSC_SCREEN   = 10'd525;
    localparam logic [CNT_W-1:0] NTSC_V_OFFSET = 10'd40;
    localparam logic [CNT_W-1:0] NTSC_H_OFFSET = 10'd32;  // ntsc picture sits 3 pixels later

    // both sets share the horizontal sync and window start,
    // they only differ in line length and in the vertical layout.
    // the vertical offsets start the counters shortly before the frame wrap
    // so a full picture shows up quickly after reset.
    // note that the line length of either set stays below the line buffer depth
    // once the horizontal offset is taken off.

endpackage

// ==== color_pkg.sv ====
package color_pkg;

    localparam int COLOR_W      = 4;             // color index width
    localparam int RGB_W        = 4;             // bits per channel
    localparam int PALETTE_SIZE = 1 << COLOR_W;  // one entry per index

    // fixed palette, 12-bit rgb packed as r,g,b nibbles
    localparam logic [3*RGB_W-1:0] PALETTE [PALETTE_SIZE] = '{
        12'h000,  // 0 black
        12'hfff,  // 1 white
        12'h833,  // 2 red
        12'h7cc,  // 3 cyan
        12'h849,  // 4 purple
        12'h6a4,  // 5 green
        12'h439,  // 6 blue
        12'hbc7,  // 7 yellow
        12'h853,  // 8 orange
        12'h540,  // 9 brown
        12'hb66,  // 10 light red
        12'h444,  // 11 dark grey
        12'h777,  // 12 mid grey
        12'hae8,  // 13 light green
        12'h87c,  // 14 light blue
        12'haaa   // 15 light grey
    };

    // index 0 doubles as the border/blank value of the line buffer,
    // so an unwritten buffer entry shows as black.
    // the table is read once per output pixel in the palette stage,
    // with the channel order r in the top nibble down to b in the bottom one.
    // values are rounded down from 8-bit levels to 4 bits per channel.
    // light and dark variants keep the same hue where the source chip has them.

endpackage

// ==== vga_mode_ctrl.sv ====
module vga_mode_ctrl #(
    parameter video_std_pkg::video_std_t RESET_STD = video_std_pkg::STD_PAL
) (
    input  logic                       clk_dot4x,
    input  logic                       rst,
    input  logic                       i_std_req,    // four-phase request
    input  logic                       i_std_pal,    // requested standard, 1 = pal
    input  logic                       i_frame_end,  // from the raster counters
    output logic                       o_std_ack,
    output video_std_pkg::video_std_t  o_std
);
    import video_std_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_FRAME,  // request seen, waiting for the frame wrap
        ACK_HOLD     // standard applied, waiting for req to fall
    } state_t;

    state_t     state;
    video_std_t req_std;
    video_std_t pend_std;  // standard taken at request time

    always_comb begin
        if (i_std_pal) req_std = STD_PAL;
        else           req_std = STD_NTSC;
    end

    always_ff @(posedge clk_dot4x) begin
        if (state == IDLE && i_std_req) pend_std <= req_std;
    end

    // std switches on the edge where the counters wrap
    always_ff @(posedge clk_dot4x) begin
        if (!rst) begin
            state     <= IDLE;
            o_std     <= RESET_STD;
            o_std_ack <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (i_std_req && i_frame_end) begin  // request lands on the wrap itself
                        o_std     <= req_std;
                        o_std_ack <= 1'b1;
                        state     <= ACK_HOLD;
                    end else if (i_std_req) begin
                        state <= WAIT_FRAME;
                    end
                end
                WAIT_FRAME: begin
                    if (i_frame_end) begin
                        o_std     <= pend_std;
                        o_std_ack <= 1'b1;
                        state     <= ACK_HOLD;
                    end
                end
                ACK_HOLD: begin
                    if (!i_std_req) begin  // requester done, release ack
                        o_std_ack <= 1'b0;
                        state     <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_ack_needs_req: assert property (@(posedge clk_dot4x) disable iff (!rst)
        $rose(o_std_ack) |-> $past(i_std_req));

endmodule

// ==== vga_sync.sv ====
module vga_sync (
    input  logic                            clk_dot4x,
    input  logic                            rst,
    input  video_std_pkg::video_std_t       i_std,
    output logic                            o_pix_en,     // half-rate advance strobe
    output logic [video_std_pkg::CNT_W-1:0] o_h_count,
    output logic [video_std_pkg::CNT_W-1:0] o_v_count,
    output logic                            o_hs,         // active low
    output logic                            o_vs,         // active low
    output logic                            o_active,
    output logic                            o_frame_end
);
    import video_std_pkg::*;

    logic [CNT_W-1:0] hs_sta;
    logic [CNT_W-1:0] hs_end;
    logic [CNT_W-1:0] ha_sta;
    logic [CNT_W-1:0] vs_sta;
    logic [CNT_W-1:0] vs_end;
    logic [CNT_W-1:0] va_end;
    logic [CNT_W-1:0] line_max;
    logic [CNT_W-1:0] screen_max;
    logic [CNT_W-1:0] v_start;

    // limits follow the standard of the current cycle
    always_comb begin
        if (i_std == STD_PAL) begin
            hs_sta     = PAL_HS_STA;
            hs_end     = PAL_HS_END;
            ha_sta     = PAL_HA_STA;
            vs_sta     = PAL_VS_STA;
            vs_end     = PAL_VS_END;
            va_end     = PAL_VA_END;
            line_max   = PAL_LINE;
            screen_max = PAL_SCREEN;
            v_start    = PAL_SCREEN - PAL_V_OFFSET;
        end else begin
            hs_sta     = NTSC_HS_STA;
            hs_end     = NTSC_HS_END;
            ha_sta     = NTSC_HA_STA;
            vs_sta     = NTSC_VS_STA;
            vs_end     = NTSC_VS_END;
            va_end     = NTSC_VA_END;
            line_max   = NTSC_LINE;
            screen_max = NTSC_SCREEN;
            v_start    = NTSC_SCREEN - NTSC_V_OFFSET;
        end
    end

    // counters move every second clock, so each source line gets two vga lines
    always_ff @(posedge clk_dot4x) begin
        if (!rst) begin
            o_pix_en  <= 1'b0;
            o_h_count <= '0;
            o_v_count <= v_start;
        end else begin
            o_pix_en <= ~o_pix_en;
            if (o_pix_en) begin
                if (o_h_count == line_max) begin
                    o_h_count <= '0;
                    if (o_v_count == screen_max) o_v_count <= '0;  // frame wrap
                    else                         o_v_count <= o_v_count + 1'b1;
                end else begin
                    o_h_count <= o_h_count + 1'b1;
                end
            end
        end
    end

    assign o_hs        = ~((o_h_count >= hs_sta) && (o_h_count < hs_end));
    assign o_vs        = ~((o_v_count >= vs_sta) && (o_v_count < vs_end));
    assign o_active    = (o_h_count >= ha_sta) && (o_v_count < va_end);
    assign o_frame_end = o_pix_en && (o_h_count == line_max) && (o_v_count == screen_max);

    a_count_range: assert property (@(posedge clk_dot4x) disable iff (!rst)
        (o_h_count <= line_max) && (o_v_count <= screen_max));

endmodule

// ==== raster_line_buffer.sv ====
module raster_line_buffer #(
    parameter int BUF_DEPTH = 520
) (
    input  logic                              clk_dot4x,
    input  logic                              rst,
    input  video_std_pkg::video_std_t         i_std,
    input  logic                              i_dot_rising,   // one strobe per source pixel
    input  logic [video_std_pkg::CNT_W-1:0]   i_raster_x,
    input  logic [color_pkg::COLOR_W-1:0]     i_pixel_color,
    input  logic [video_std_pkg::CNT_W-1:0]   i_h_count,
    output logic [color_pkg::COLOR_W-1:0]     o_rd_color
);
    import video_std_pkg::*;
    import color_pkg::*;

    logic [COLOR_W-1:0] line_buf_0 [BUF_DEPTH];
    logic [COLOR_W-1:0] line_buf_1 [BUF_DEPTH];
    logic               wr_bank;      // bank the source is filling
    logic               wr_bank_nxt;
    logic               wr_en;
    logic [CNT_W-1:0]   h_off;
    logic               rd_blank;     // left of buffer pixel 0
    logic [CNT_W-1:0]   rd_addr;
    logic               rd_bank_q;
    logic               rd_blank_q;
    logic [COLOR_W-1:0] rd_0_q;
    logic [COLOR_W-1:0] rd_1_q;

    initial begin
        for (int i = 0; i < BUF_DEPTH; i++) begin
            line_buf_0[i] = '0;
            line_buf_1[i] = '0;
        end
    end

    assign wr_en       = i_dot_rising && rst;
    assign wr_bank_nxt = (i_raster_x == '0) ? ~wr_bank : wr_bank;  // new line, swap banks

    always_ff @(posedge clk_dot4x) begin
        if (!rst)              wr_bank <= 1'b0;
        else if (i_dot_rising) wr_bank <= wr_bank_nxt;
    end

    always_ff @(posedge clk_dot4x) begin
        if (wr_en) begin
            if (wr_bank_nxt) line_buf_1[i_raster_x] <= i_pixel_color;
            else             line_buf_0[i_raster_x] <= i_pixel_color;
        end
    end

    assign h_off    = (i_std == STD_PAL) ? PAL_H_OFFSET : NTSC_H_OFFSET;
    assign rd_blank = i_h_count < h_off;
    assign rd_addr  = rd_blank ? '0 : i_h_count - h_off;  // clamp keeps the read in range

    // read both banks, pick the one not being written
    always_ff @(posedge clk_dot4x) begin
        rd_0_q     <= line_buf_0[rd_addr];
        rd_1_q     <= line_buf_1[rd_addr];
        rd_bank_q  <= ~wr_bank;
        rd_blank_q <= rd_blank;
    end

    assign o_rd_color = rd_blank_q ? '0 : (rd_bank_q ? rd_1_q : rd_0_q);

    a_wr_addr: assert property (@(posedge clk_dot4x) disable iff (!rst)
        i_dot_rising |-> (i_raster_x < BUF_DEPTH));
    // the raster limits of vga_sync must fit the depth chosen at the top
    a_rd_addr: assert property (@(posedge clk_dot4x) disable iff (!rst)
        rd_addr < BUF_DEPTH);

endmodule

// ==== palette_lookup.sv ====
module palette_lookup (
    input  logic                            clk_dot4x,
    input  logic                            rst,
    input  logic [color_pkg::COLOR_W-1:0]   i_color,   // one cycle behind the counters
    input  logic                            i_hs,
    input  logic                            i_vs,
    input  logic                            i_active,
    output logic [3*color_pkg::RGB_W-1:0]   o_rgb,
    output logic                            o_hs,
    output logic                            o_vs,
    output logic                            o_active
);
    import color_pkg::*;

    logic hs_d;      // first delay stage, lines up with i_color
    logic vs_d;
    logic active_d;

    always_ff @(posedge clk_dot4x) begin
        if (!rst) begin
            hs_d     <= 1'b1;
            vs_d     <= 1'b1;
            active_d <= 1'b0;
            o_hs     <= 1'b1;  // syncs idle high
            o_vs     <= 1'b1;
            o_active <= 1'b0;
            o_rgb    <= '0;
        end else begin
            hs_d     <= i_hs;
            vs_d     <= i_vs;
            active_d <= i_active;
            o_hs     <= hs_d;
            o_vs     <= vs_d;
            o_active <= active_d;
            o_rgb    <= active_d ? PALETTE[i_color] : '0;  // black outside the window
        end
    end

endmodule

// ==== vic_vga_out.sv ====
module vic_vga_out #(
    parameter int                        BUF_DEPTH = 520,
    parameter video_std_pkg::video_std_t RESET_STD = video_std_pkg::STD_PAL
) (
    input  logic                            clk_dot4x,
    input  logic                            rst,
    input  logic                            i_dot_rising,
    input  logic [video_std_pkg::CNT_W-1:0] i_raster_x,
    input  logic [color_pkg::COLOR_W-1:0]   i_pixel_color,
    input  logic                            i_std_req,
    input  logic                            i_std_pal,
    output logic                            o_std_ack,
    output logic                            o_hs,
    output logic                            o_vs,
    output logic                            o_active,
    output logic [3*color_pkg::RGB_W-1:0]   o_rgb
);
    import video_std_pkg::*;
    import color_pkg::*;

    video_std_t         std;
    logic               frame_end;
    logic [CNT_W-1:0]   h_count;
    logic               hs;
    logic               vs;
    logic               active;
    logic [COLOR_W-1:0] rd_color;

    vga_mode_ctrl #(.RESET_STD(RESET_STD)) vga_mode_ctrl_inst (
        .clk_dot4x   (clk_dot4x),
        .rst         (rst),
        .i_std_req   (i_std_req),
        .i_std_pal   (i_std_pal),
        .i_frame_end (frame_end),
        .o_std_ack   (o_std_ack),
        .o_std       (std)
    );

    // pix_en and v count are not needed past the counters
    vga_sync vga_sync_inst (
        .clk_dot4x   (clk_dot4x),
        .rst         (rst),
        .i_std       (std),
        .o_pix_en    (),
        .o_h_count   (h_count),
        .o_v_count   (),
        .o_hs        (hs),
        .o_vs        (vs),
        .o_active    (active),
        .o_frame_end (frame_end)
    );

    raster_line_buffer #(.BUF_DEPTH(BUF_DEPTH)) raster_line_buffer_inst (
        .clk_dot4x     (clk_dot4x),
        .rst           (rst),
        .i_std         (std),
        .i_dot_rising  (i_dot_rising),
        .i_raster_x    (i_raster_x),
        .i_pixel_color (i_pixel_color),
        .i_h_count     (h_count),
        .o_rd_color    (rd_color)
    );

    palette_lookup palette_lookup_inst (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .i_color   (rd_color),
        .i_hs      (hs),
        .i_vs      (vs),
        .i_active  (active),
        .o_rgb     (o_rgb),
        .o_hs      (o_hs),
        .o_vs      (o_vs),
        .o_active  (o_active)
    );

endmodule

// ==== tb_vic_vga_out.sv ====
module tb_vic_vga_out;
    timeunit 1ns;
    timeprecision 100ps;
    import video_std_pkg::*;

    localparam int DEPTH      = 520;
    localparam int PAL_FRAME  = 2 * (int'(PAL_LINE) + 1) * (int'(PAL_SCREEN) + 1);
    localparam int NTSC_FRAME = 2 * (int'(NTSC_LINE) + 1) * (int'(NTSC_SCREEN) + 1);
    // startup frame, pal frame, two request waits, ntsc frame, last pal frame
    localparam longint WATCHDOG_NS = 4 * longint'(3 * PAL_FRAME + 2 * NTSC_FRAME + 200_000);

    // reference palette, r g b nibbles
    localparam logic [11:0] RGB_OF [16] = '{
        12'h000, 12'hfff, 12'h833, 12'h7cc, 12'h849, 12'h6a4, 12'h439, 12'hbc7,
        12'h853, 12'h540, 12'hb66, 12'h444, 12'h777, 12'hae8, 12'h87c, 12'haaa
    };

    logic        clk_dot4x;
    logic        rst;
    logic        i_dot_rising;
    logic [9:0]  i_raster_x;
    logic [3:0]  i_pixel_color;
    logic        i_std_req;
    logic        i_std_pal;
    logic        o_std_ack;
    logic        o_hs;
    logic        o_vs;
    logic        o_active;
    logic [11:0] o_rgb;

    // reference model state
    int          m_h;
    int          m_v;
    logic        m_pix_en;
    logic        m_pal;       // 1 = pal timing
    logic        m_wr_bank;
    logic        m_ack;
    logic        m_fe;        // frame end seen at the last edge
    logic [3:0]  m_buf [2][DEPTH];
    logic [3:0]  m_rd;        // registered buffer read
    logic        m_hs_d;
    logic        m_vs_d;
    logic        m_act_d;
    logic        m_hs;
    logic        m_vs;
    logic        m_act;
    logic [11:0] m_rgb;

    logic [31:0] lcg_state;
    int          src_x;
    int          src_gap;     // cycles until the next source pixel
    logic        src_on;
    int          active_cycles;
    string       test_name;

    vic_vga_out #(.BUF_DEPTH(DEPTH), .RESET_STD(STD_PAL)) vic_vga_out_inst (.*);

    always #2 clk_dot4x = ~clk_dot4x;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int pick(logic pal, logic [CNT_W-1:0] p, logic [CNT_W-1:0] n);
        return pal ? int'(p) : int'(n);
    endfunction

    task automatic fail_run(string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
        if (act !== exp) begin
            $display("** Error %s: expected %0h, actual %0h at %0t", name, exp, act, $time);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // one clock of the whole chain, using the inputs seen at this edge
    task automatic model_step();
        int         line_max;
        int         screen_max;
        int         h_off;
        logic       hs_c;
        logic       vs_c;
        logic       act_c;
        logic [3:0] rd_new;
        logic       nb;
        line_max   = pick(m_pal, PAL_LINE, NTSC_LINE);
        screen_max = pick(m_pal, PAL_SCREEN, NTSC_SCREEN);
        h_off      = pick(m_pal, PAL_H_OFFSET, NTSC_H_OFFSET);
        if (!rst) begin
            m_pix_en  = 1'b0;
            m_h       = 0;
            m_pal     = 1'b1;
            m_v       = int'(PAL_SCREEN) - int'(PAL_V_OFFSET);
            m_wr_bank = 1'b0;
            m_ack     = 1'b0;
            m_fe      = 1'b0;
            m_rd      = 4'd0;
            m_hs_d    = 1'b1;
            m_vs_d    = 1'b1;
            m_act_d   = 1'b0;
            m_hs      = 1'b1;
            m_vs      = 1'b1;
            m_act     = 1'b0;
            m_rgb     = 12'd0;
        end else begin
            hs_c  = !(m_h >= pick(m_pal, PAL_HS_STA, NTSC_HS_STA)
                      && m_h < pick(m_pal, PAL_HS_END, NTSC_HS_END));
            vs_c  = !(m_v >= pick(m_pal, PAL_VS_STA, NTSC_VS_STA)
                      && m_v < pick(m_pal, PAL_VS_END, NTSC_VS_END));
            act_c = m_h >= pick(m_pal, PAL_HA_STA, NTSC_HA_STA)
                    && m_v < pick(m_pal, PAL_VA_END, NTSC_VA_END);
            m_fe  = m_pix_en && m_h == line_max && m_v == screen_max;
            rd_new = (m_h < h_off) ? 4'd0 : m_buf[~m_wr_bank][m_h - h_off];  // old bank
            m_rgb   = m_act_d ? RGB_OF[m_rd] : 12'd0;
            m_hs    = m_hs_d;
            m_vs    = m_vs_d;
            m_act   = m_act_d;
            m_hs_d  = hs_c;
            m_vs_d  = vs_c;
            m_act_d = act_c;
            m_rd    = rd_new;
            if (i_dot_rising) begin
                nb = (i_raster_x == 10'd0) ? ~m_wr_bank : m_wr_bank;  // x 0 opens a line
                m_buf[nb][i_raster_x] = i_pixel_color;
                m_wr_bank = nb;
            end
            if (m_ack) begin
                m_ack = i_std_req;  // released the edge after req drops
            end else if (i_std_req && m_fe) begin
                m_ack = 1'b1;
                m_pal = i_std_pal;  // limits of the old std still move the counters below
            end
            if (m_pix_en) begin
                if (m_h == line_max) begin
                    m_h = 0;
                    m_v = (m_v == screen_max) ? 0 : m_v + 1;
                end else begin
                    m_h = m_h + 1;
                end
            end
            m_pix_en = ~m_pix_en;
        end
    endtask

    task automatic drive_source();
        logic [31:0] r;
        i_dot_rising = 1'b0;
        if (src_on) begin
            if (src_gap == 0) begin
                r = lcg_next();
                i_dot_rising  = 1'b1;
                i_raster_x    = 10'(src_x);
                i_pixel_color = r[19:16];
                src_x   = (src_x == 399) ? 0 : src_x + 1;
                src_gap = 2 + int'(r[29:28]);  // next pixel 3 to 6 cycles later
            end else begin
                src_gap--;
            end
        end
    endtask

    // edge, model, compare half a ns later, then new inputs
    task automatic tick();
        @(posedge clk_dot4x);
        model_step();
        #0.5;
        check_val({test_name, " o_hs"}, 32'(m_hs), 32'(o_hs));
        check_val({test_name, " o_vs"}, 32'(m_vs), 32'(o_vs));
        check_val({test_name, " o_active"}, 32'(m_act), 32'(o_active));
        check_val({test_name, " o_rgb"}, 32'(m_rgb), 32'(o_rgb));
        check_val({test_name, " o_std_ack"}, 32'(m_ack), 32'(o_std_ack));
        if (o_active !== 1'b1) check_val({test_name, " blank rgb"}, 32'd0, 32'(o_rgb));
        if (o_active === 1'b1) active_cycles++;
        drive_source();
    endtask

    task automatic run_to_frame_end();
        int n;
        n = 0;
        do begin
            tick();
            n++;
            if (n > PAL_FRAME + 16) fail_run("no frame end seen within one PAL frame");
        end while (!m_fe);
    endtask

    // four-phase request, ack expected at the next frame wrap
    task automatic change_std(logic to_pal);
        int n;
        i_std_pal = to_pal;
        i_std_req = 1'b1;
        n = 0;
        while (o_std_ack !== 1'b1) begin
            tick();
            n++;
            if (n > PAL_FRAME + 16) fail_run("no ack for the standard change request");
        end
        // requested right after a wrap, so the wait is one frame of the old standard
        check_val({test_name, " ack at frame end"},
                  32'(to_pal ? NTSC_FRAME : PAL_FRAME), 32'(n));
        active_cycles = 0;  // new frame starts here
        repeat (5) tick();
        check_val({test_name, " ack held"}, 32'd1, 32'(o_std_ack));
        i_std_req = 1'b0;
        tick();
        check_val({test_name, " ack released"}, 32'd0, 32'(o_std_ack));
    endtask

    initial begin
        int n;
        clk_dot4x     = 1'b0;
        rst           = 1'b0;
        i_dot_rising  = 1'b0;
        i_raster_x    = 10'd0;
        i_pixel_color = 4'd0;
        i_std_req     = 1'b0;
        i_std_pal     = 1'b1;
        lcg_state     = 32'd92;
        src_x         = 0;
        src_gap       = 0;
        src_on        = 1'b0;
        active_cycles = 0;
        for (int i = 0; i < DEPTH; i++) begin
            m_buf[0][i] = 4'd0;
            m_buf[1][i] = 4'd0;
        end
        test_name = "reset";
        repeat (16) tick();
        rst = 1'b1;
        check_val("reset o_hs", 32'd1, 32'(o_hs));
        check_val("reset o_vs", 32'd1, 32'(o_vs));
        check_val("reset o_active", 32'd0, 32'(o_active));
        check_val("reset o_rgb", 32'd0, 32'(o_rgb));
        check_val("reset o_std_ack", 32'd0, 32'(o_std_ack));

        // two clocks per h count plus the two output stages
        test_name = "first_hsync";
        src_on = 1'b1;
        n = 0;
        do begin
            tick();
            n++;
        end while (o_hs === 1'b1 && n < 100);
        check_val("first_hsync cycles", 32'(2 * int'(PAL_HS_STA) + 2), 32'(n));

        test_name = "pal_frame";
        run_to_frame_end();  // rest of the startup frame
        run_to_frame_end();

        test_name = "to_ntsc";
        change_std(1'b0);
        run_to_frame_end();
        check_val("to_ntsc active cycles",
                  32'(2 * (int'(NTSC_LINE) + 1 - int'(NTSC_HA_STA)) * int'(NTSC_VA_END)),
                  32'(active_cycles));

        test_name = "to_pal";
        change_std(1'b1);
        run_to_frame_end();
        check_val("to_pal active cycles",
                  32'(2 * (int'(PAL_LINE) + 1 - int'(PAL_HA_STA)) * int'(PAL_VA_END)),
                  32'(active_cycles));

        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run("timeout: the test sequence did not finish in the expected time");
    end

endmodule

// ==== vic_vga_out.f ====
video_std_pkg.sv
color_pkg.sv
vga_mode_ctrl.sv
vga_sync.sv
raster_line_buffer.sv
palette_lookup.sv
vic_vga_out.sv
tb_vic_vga_out.sv

// ==== Makefile ====
TOP := tb_vic_vga_out

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f vic_vga_out.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
